// ==== hdl/loader_cfg.svh ====
// Loader widths, host file indexes, cartridge header offsets and fixed addresses
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// ==============================
// Bus widths
// ==============================
`define LDR_ADDR_W 25
`define LDR_DATA_W 8

// Host file indexes
`define LDR_IDX_PRG 4
`define LDR_IDX_CRT 5

// ==============================
// Cartridge image layout
// ==============================
`define LDR_CRT_BASE 'h100000
`define LDR_CRT_ID_HI 'h16
`define LDR_CRT_ID_LO 'h17
`define LDR_CRT_EXROM 'h18
`define LDR_CRT_GAME 'h19
`define LDR_CRT_PKT_START 'h40
`define LDR_BANK_ALIGN_BITS 13
`define LDR_CHIP_HDR_LEN 16

// Walk over page zero ends here
`define LDR_MEMINIT_END 'h100

// Pending writes ahead of the memory slot
`define LDR_QUEUE_DEPTH 4

`endif

// ==== hdl/loader_pkg.sv ====
// Types of the host download stream and of the cartridge bank records
`include "loader_cfg.svh"

package loader_pkg;

	// ==============================
	// Host download stream
	// ==============================

	// Index of the file kind, held for the whole download
	typedef logic [7:0] file_idx_t;

	// Byte offset inside the file
	typedef logic [`LDR_ADDR_W-1:0] file_addr_t;

	// ==============================
	// Cartridge records
	// ==============================

	// Big-endian header field
	// Used for the cartridge id and the bank number, load address and size
	typedef logic [15:0] word16_t;

	// Chip type of a packet (ROM, RAM, flash)
	typedef logic [7:0] bank_type_t;

	// Raw exrom and game bytes of the file header
	typedef logic [7:0] flag_byte_t;

endpackage

// ==== hdl/mem_pkg.sv ====
// Types of the system memory write path
`include "loader_cfg.svh"

package mem_pkg;

	// System memory address and byte
	typedef logic [`LDR_ADDR_W-1:0] mem_addr_t;
	typedef logic [`LDR_DATA_W-1:0] mem_data_t;

	// One write waiting for a memory slot
	typedef struct packed {
		mem_addr_t addr;
		mem_data_t data;
	} mem_wr_t;

endpackage

// ==== hdl/image_parser.sv ====
// Program and cartridge stream parser with BASIC pointer writes after a program load
`timescale 1ns/1ps
`include "loader_cfg.svh"

module image_parser (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   ioctl_download_i,
	input  loader_pkg::file_idx_t  ioctl_index_i,
	input  logic                   ioctl_wr_i,
	input  loader_pkg::file_addr_t ioctl_addr_i,
	input  mem_pkg::mem_data_t     ioctl_data_i,
	output logic                   ioctl_wait_o,
	input  logic                   full_i,
	output logic                   push_o,
	output mem_pkg::mem_addr_t     push_addr_o,
	output mem_pkg::mem_data_t     push_data_o,
	output loader_pkg::word16_t    cart_id_o,
	output loader_pkg::flag_byte_t cart_exrom_o,
	output loader_pkg::flag_byte_t cart_game_o,
	output logic                   cart_attached_o,
	output logic                   bank_hdr_wr_o,
	output loader_pkg::bank_type_t bank_type_o,
	output loader_pkg::word16_t    bank_num_o,
	output loader_pkg::word16_t    bank_laddr_o,
	output loader_pkg::word16_t    bank_size_o,
	output mem_pkg::mem_addr_t     bank_raddr_o
);

	localparam mem_pkg::mem_addr_t ALIGN_MASK =
		mem_pkg::mem_addr_t'((1 << `LDR_BANK_ALIGN_BITS) - 1);

	loader_pkg::file_idx_t  idx_q;
	loader_pkg::file_idx_t  cur_idx;
	logic                   old_download;
	logic                   dl_edge;
	logic                   dl_fall;
	logic                   load_prg;
	logic                   load_crt;
	logic                   byte_wr;

	mem_pkg::mem_addr_t     load_addr;
	mem_pkg::mem_addr_t     load_addr_aligned;
	loader_pkg::word16_t    end_addr;

	logic                   meminit;
	logic                   ptr_hit;
	mem_pkg::mem_data_t     ptr_data;

	logic [3:0]             hdr_cnt;
	logic [31:0]            blk_len;
	loader_pkg::bank_type_t hdr_type;
	loader_pkg::word16_t    hdr_num;
	loader_pkg::word16_t    hdr_laddr;
	mem_pkg::mem_data_t     hdr_size_hi;

	// Host pauses whenever the queue is nearly full
	assign ioctl_wait_o = full_i;

	// Index is still known in the cycle the download level falls
	assign cur_idx  = ioctl_download_i ? ioctl_index_i : idx_q;
	assign load_prg = (cur_idx == loader_pkg::file_idx_t'(`LDR_IDX_PRG));
	assign load_crt = (cur_idx == loader_pkg::file_idx_t'(`LDR_IDX_CRT));
	assign dl_edge  = (old_download != ioctl_download_i);
	assign dl_fall  = old_download & ~ioctl_download_i;
	assign byte_wr  = ioctl_wr_i & ioctl_download_i;

	// Round up to the next bank boundary, unchanged when already aligned
	assign load_addr_aligned = (load_addr + ALIGN_MASK) & ~ALIGN_MASK;

	// ==============================
	// BASIC pointer page
	// ==============================
	always_comb begin
		ptr_hit  = 1'b1;
		ptr_data = '0;
		case (load_addr)
			// Text start as after reset
			'h2B: ptr_data = 8'h01;
			'h2C: ptr_data = 8'h08;
			'hAC, 'hAD: ptr_data = 8'h00;
			// Variables, arrays, strings and load end all point past the program
			'h2D, 'h2F, 'h31, 'hAE: ptr_data = end_addr[7:0];
			'h2E, 'h30, 'h32, 'hAF: ptr_data = end_addr[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			idx_q           <= '0;
			old_download    <= 1'b0;
			push_o          <= 1'b0;
			bank_hdr_wr_o   <= 1'b0;
			cart_attached_o <= 1'b0;
			meminit         <= 1'b0;
			hdr_cnt         <= '0;
			blk_len         <= '0;
		end else begin
			old_download  <= ioctl_download_i;
			push_o        <= 1'b0;
			bank_hdr_wr_o <= 1'b0;
			if (ioctl_download_i) begin
				idx_q <= ioctl_index_i;
			end

			// ==============================
			// Program file
			// ==============================
			if (byte_wr && load_prg) begin
				if (ioctl_addr_i == 0) begin
					load_addr     <= mem_pkg::mem_addr_t'(ioctl_data_i);
					end_addr[7:0] <= ioctl_data_i;
				end else if (ioctl_addr_i == 1) begin
					load_addr[15:8] <= ioctl_data_i;
					end_addr[15:8]  <= ioctl_data_i;
				end else begin
					push_o      <= 1'b1;
					push_addr_o <= load_addr;
					push_data_o <= ioctl_data_i;
					load_addr   <= load_addr + 1'b1;
					end_addr    <= end_addr + 1'b1;
				end
			end

			// ==============================
			// Cartridge file
			// ==============================
			if (byte_wr && load_crt) begin
				if (ioctl_addr_i == 0) begin
					load_addr <= mem_pkg::mem_addr_t'(`LDR_CRT_BASE);
					blk_len   <= '0;
					hdr_cnt   <= '0;
				end
				if (ioctl_addr_i == `LDR_CRT_ID_HI) begin
					cart_id_o[15:8] <= ioctl_data_i;
				end
				if (ioctl_addr_i == `LDR_CRT_ID_LO) begin
					cart_id_o[7:0] <= ioctl_data_i;
				end
				if (ioctl_addr_i == `LDR_CRT_EXROM) begin
					cart_exrom_o <= ioctl_data_i;
				end
				if (ioctl_addr_i == `LDR_CRT_GAME) begin
					cart_game_o <= ioctl_data_i;
				end

				if (ioctl_addr_i >= `LDR_CRT_PKT_START) begin
					if (blk_len == 0 && hdr_cnt == 0) begin
						// First chip header byte, bank data starts on a fresh 8 KB page
						hdr_cnt   <= 4'd1;
						load_addr <= load_addr_aligned;
					end else if (hdr_cnt != 0) begin
						hdr_cnt <= hdr_cnt + 4'd1;
						case (hdr_cnt)
							4'd4: blk_len[31:24] <= ioctl_data_i;
							4'd5: blk_len[23:16] <= ioctl_data_i;
							4'd6: blk_len[15:8] <= ioctl_data_i;
							4'd7: blk_len[7:0] <= ioctl_data_i;
							// Packet length includes its own header
							4'd8: blk_len <= blk_len - `LDR_CHIP_HDR_LEN;
							4'd9: hdr_type <= ioctl_data_i;
							4'd10: hdr_num[15:8] <= ioctl_data_i;
							4'd11: hdr_num[7:0] <= ioctl_data_i;
							4'd12: hdr_laddr[15:8] <= ioctl_data_i;
							4'd13: hdr_laddr[7:0] <= ioctl_data_i;
							4'd14: hdr_size_hi <= ioctl_data_i;
							4'd15: begin
								bank_hdr_wr_o <= 1'b1;
								bank_type_o   <= hdr_type;
								bank_num_o    <= hdr_num;
								bank_laddr_o  <= hdr_laddr;
								bank_size_o   <= {hdr_size_hi, ioctl_data_i};
								bank_raddr_o  <= load_addr;
							end
							default: ;
						endcase
					end else begin
						blk_len     <= blk_len - 1'b1;
						push_o      <= 1'b1;
						push_addr_o <= load_addr;
						push_data_o <= ioctl_data_i;
						load_addr   <= load_addr + 1'b1;
					end
				end
			end

			// Attached once a cartridge download ends, detached when the next one starts
			if (dl_edge && load_crt) begin
				cart_attached_o <= old_download;
			end

			// Page walk after a program download
			if (dl_fall && load_prg) begin
				meminit   <= 1'b1;
				load_addr <= '0;
			end
			if (meminit) begin
				if (load_addr == `LDR_MEMINIT_END) begin
					meminit <= 1'b0;
				end else if (!ptr_hit || !full_i) begin
					push_o      <= ptr_hit;
					push_addr_o <= load_addr;
					push_data_o <= ptr_data;
					load_addr   <= load_addr + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/write_queue.sv ====
// FIFO of pending memory writes with an early full level
`timescale 1ns/1ps
`include "loader_cfg.svh"

module write_queue #(
	parameter int DEPTH = `LDR_QUEUE_DEPTH
) (
	input  logic               clk_sys,
	input  logic               reset_n,
	input  logic               push_i,
	input  mem_pkg::mem_addr_t push_addr_i,
	input  mem_pkg::mem_data_t push_data_i,
	output logic               full_o,
	input  logic               pop_i,
	output logic               pop_valid_o,
	output mem_pkg::mem_addr_t pop_addr_o,
	output mem_pkg::mem_data_t pop_data_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	mem_pkg::mem_wr_t entries [DEPTH];
	mem_pkg::mem_wr_t head;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Pointer wrap for any depth
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (push_i) begin
			entries[wr_ptr] <= '{addr: push_addr_i, data: push_data_i};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop_i) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push_i, pop_i})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	assign head        = entries[rd_ptr];
	assign pop_valid_o = (count != '0);
	assign pop_addr_o  = head.addr;
	assign pop_data_o  = head.data;

	// Last free entry is kept for the push already in flight
	assign full_o = (count >= CNT_W'(DEPTH - 1));

endmodule

// ==== hdl/slot_writer.sv ====
// Memory slot writer issuing one queued write per slot
`timescale 1ns/1ps

module slot_writer (
	input  logic               clk_sys,
	input  logic               reset_n,
	input  logic               io_cycle_i,
	input  logic               pop_valid_i,
	input  mem_pkg::mem_addr_t pop_addr_i,
	input  mem_pkg::mem_data_t pop_data_i,
	output logic               pop_o,
	output logic               mem_we_o,
	output mem_pkg::mem_addr_t mem_addr_o,
	output mem_pkg::mem_data_t mem_data_o
);

	logic io_cycle_q;
	logic slot_open;

	// Slot opens on the falling edge of the io cycle level
	assign slot_open = ~io_cycle_i & io_cycle_q;
	assign pop_o     = slot_open & pop_valid_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_q <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			io_cycle_q <= io_cycle_i;
			mem_we_o   <= pop_o;
		end
	end

	// Head entry moves to the memory port together with the write pulse
	always_ff @(posedge clk_sys) begin
		if (pop_o) begin
			mem_addr_o <= pop_addr_i;
			mem_data_o <= pop_data_i;
		end
	end

endmodule

// ==== hdl/loader_top.sv ====
// File loader top level with parser, write queue and slot writer
`timescale 1ns/1ps
`include "loader_cfg.svh"

module loader_top (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	input  logic                   ioctl_download_i,
	input  loader_pkg::file_idx_t  ioctl_index_i,
	input  logic                   ioctl_wr_i,
	input  loader_pkg::file_addr_t ioctl_addr_i,
	input  mem_pkg::mem_data_t     ioctl_data_i,
	output logic                   ioctl_wait_o,
	input  logic                   io_cycle_i,
	output logic                   mem_we_o,
	output mem_pkg::mem_addr_t     mem_addr_o,
	output mem_pkg::mem_data_t     mem_data_o,
	output loader_pkg::word16_t    cart_id_o,
	output loader_pkg::flag_byte_t cart_exrom_o,
	output loader_pkg::flag_byte_t cart_game_o,
	output logic                   cart_attached_o,
	output logic                   bank_hdr_wr_o,
	output loader_pkg::bank_type_t bank_type_o,
	output loader_pkg::word16_t    bank_num_o,
	output loader_pkg::word16_t    bank_laddr_o,
	output loader_pkg::word16_t    bank_size_o,
	output mem_pkg::mem_addr_t     bank_raddr_o
);

	// Parser to queue
	logic               push;
	mem_pkg::mem_addr_t push_addr;
	mem_pkg::mem_data_t push_data;
	logic               full;

	// Queue to slot writer
	logic               pop;
	logic               pop_valid;
	mem_pkg::mem_addr_t pop_addr;
	mem_pkg::mem_data_t pop_data;

	image_parser i_parser (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.full_i           (full),
		.push_o           (push),
		.push_addr_o      (push_addr),
		.push_data_o      (push_data),
		.cart_id_o        (cart_id_o),
		.cart_exrom_o     (cart_exrom_o),
		.cart_game_o      (cart_game_o),
		.cart_attached_o  (cart_attached_o),
		.bank_hdr_wr_o    (bank_hdr_wr_o),
		.bank_type_o      (bank_type_o),
		.bank_num_o       (bank_num_o),
		.bank_laddr_o     (bank_laddr_o),
		.bank_size_o      (bank_size_o),
		.bank_raddr_o     (bank_raddr_o)
	);

	write_queue #(
		.DEPTH (`LDR_QUEUE_DEPTH)
	) i_queue (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.push_i      (push),
		.push_addr_i (push_addr),
		.push_data_i (push_data),
		.full_o      (full),
		.pop_i       (pop),
		.pop_valid_o (pop_valid),
		.pop_addr_o  (pop_addr),
		.pop_data_o  (pop_data)
	);

	slot_writer i_writer (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.io_cycle_i  (io_cycle_i),
		.pop_valid_i (pop_valid),
		.pop_addr_i  (pop_addr),
		.pop_data_i  (pop_data),
		.pop_o       (pop),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o)
	);

endmodule

// ==== tests/tb_loader_checks.svh ====
// Compare tasks for the loader outputs and host byte-stream tasks

	// ==============================
	// Compare tasks
	// ==============================
	task automatic check_mem_wr(input mem_pkg::mem_addr_t got_addr,
		input mem_pkg::mem_data_t got_data, input mem_pkg::mem_addr_t exp_addr,
		input mem_pkg::mem_data_t exp_data, input string what);
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			report_error($sformatf("%s: write 0x%h <= 0x%h, expected 0x%h <= 0x%h",
				what, got_addr, got_data, exp_addr, exp_data));
		end
	endtask

	task automatic check_word16(input loader_pkg::word16_t got,
		input loader_pkg::word16_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s is 0x%h, expected 0x%h", what, got, exp));
		end
	endtask

	task automatic check_flag_byte(input loader_pkg::flag_byte_t got,
		input loader_pkg::flag_byte_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s is 0x%h, expected 0x%h", what, got, exp));
		end
	endtask

	task automatic check_bank_type(input loader_pkg::bank_type_t got,
		input loader_pkg::bank_type_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s is 0x%h, expected 0x%h", what, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_bank_raddr(input mem_pkg::mem_addr_t got,
		input mem_pkg::mem_addr_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s is 0x%h, expected 0x%h", what, got, exp));
		end
	endtask

	// ==============================
	// Host byte stream
	// ==============================
	task automatic send_byte(input loader_pkg::file_addr_t addr, input mem_pkg::mem_data_t data);
		@(posedge clk_sys);
		#1;
		// Host holds off while the queue is nearly full
		while (ioctl_wait_o) begin
			wait_seen = 1'b1;
			@(posedge clk_sys);
			#1;
		end
		ioctl_wr_i   = 1'b1;
		ioctl_addr_i = addr;
		ioctl_data_i = data;
		@(posedge clk_sys);
		#1;
		ioctl_wr_i = 1'b0;
	endtask

	task automatic send_file(input loader_pkg::file_idx_t idx);
		@(posedge clk_sys);
		#1;
		ioctl_index_i    = idx;
		ioctl_download_i = 1'b1;
		foreach (file_bytes[i]) begin
			send_byte(loader_pkg::file_addr_t'(i), file_bytes[i]);
		end
		@(posedge clk_sys);
		#1;
		ioctl_download_i = 1'b0;
	endtask

// ==== tests/tb_loader.sv ====
// Loader testbench with stimulus table, memory and bank monitors and timeout
`timescale 1ns/1ps
`include "loader_cfg.svh"

module tb_loader;

	localparam int ROWS = 3;
	// Pointer bytes written in page zero after a program load
	localparam int PTR_WRITES = 12;

	// Program rows use load and len0, cartridge rows the header and packet fields
	typedef struct packed {
		loader_pkg::file_idx_t  idx;
		logic [15:0]            load;
		logic [7:0]             len0;
		logic [7:0]             len1;
		loader_pkg::word16_t    id;
		loader_pkg::flag_byte_t exrom;
		loader_pkg::flag_byte_t game;
		loader_pkg::word16_t    laddr0;
		loader_pkg::word16_t    laddr1;
		logic [7:0]             hold;
	} row_t;

	typedef struct packed {
		loader_pkg::bank_type_t btype;
		loader_pkg::word16_t    num;
		loader_pkg::word16_t    laddr;
		loader_pkg::word16_t    size;
		mem_pkg::mem_addr_t     raddr;
	} bank_rec_t;

	logic                   clk_sys;
	logic                   reset_n;
	logic                   ioctl_download_i;
	loader_pkg::file_idx_t  ioctl_index_i;
	logic                   ioctl_wr_i;
	loader_pkg::file_addr_t ioctl_addr_i;
	mem_pkg::mem_data_t     ioctl_data_i;
	logic                   ioctl_wait_o;
	logic                   io_cycle_i = 1'b0;
	logic                   mem_we_o;
	mem_pkg::mem_addr_t     mem_addr_o;
	mem_pkg::mem_data_t     mem_data_o;
	loader_pkg::word16_t    cart_id_o;
	loader_pkg::flag_byte_t cart_exrom_o;
	loader_pkg::flag_byte_t cart_game_o;
	logic                   cart_attached_o;
	logic                   bank_hdr_wr_o;
	loader_pkg::bank_type_t bank_type_o;
	loader_pkg::word16_t    bank_num_o;
	loader_pkg::word16_t    bank_laddr_o;
	loader_pkg::word16_t    bank_size_o;
	mem_pkg::mem_addr_t     bank_raddr_o;

	row_t                   stim_rows [ROWS];
	mem_pkg::mem_data_t     file_bytes [$];
	mem_pkg::mem_wr_t       exp_wr [$];
	mem_pkg::mem_wr_t       got_wr [$];
	bank_rec_t              exp_bank [$];
	bank_rec_t              got_bank [$];
	integer                 seed = 30;
	int                     cycle_cnt = 0;
	int                     cycle_limit;
	int                     hold_until;
	logic                   wait_seen;

	loader_top i_dut (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.io_cycle_i       (io_cycle_i),
		.mem_we_o         (mem_we_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_o       (mem_data_o),
		.cart_id_o        (cart_id_o),
		.cart_exrom_o     (cart_exrom_o),
		.cart_game_o      (cart_game_o),
		.cart_attached_o  (cart_attached_o),
		.bank_hdr_wr_o    (bank_hdr_wr_o),
		.bank_type_o      (bank_type_o),
		.bank_num_o       (bank_num_o),
		.bank_laddr_o     (bank_laddr_o),
		.bank_size_o      (bank_size_o),
		.bank_raddr_o     (bank_raddr_o)
	);

	`include "tb_loader_checks.svh"

	always #5 clk_sys = ~clk_sys;

	task automatic report_error(input string msg);
		$display("FAILED @ %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// ==============================
	// Monitors, slots and timeout
	// ==============================
	always @(negedge clk_sys) begin
		if (reset_n && mem_we_o) begin
			got_wr.push_back({mem_addr_o, mem_data_o});
		end
		if (reset_n && bank_hdr_wr_o) begin
			got_bank.push_back({bank_type_o, bank_num_o, bank_laddr_o, bank_size_o, bank_raddr_o});
		end
	end

	// Random io cycle level, held high while slots are withheld
	always @(posedge clk_sys) begin
		#1;
		if (cycle_cnt < hold_until) begin
			io_cycle_i = 1'b1;
		end else begin
			io_cycle_i = 1'($random(seed));
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	// ==============================
	// Expected values
	// ==============================
	task automatic add_wr(input int addr, input int data);
		mem_pkg::mem_wr_t w;
		w.addr = mem_pkg::mem_addr_t'(addr);
		w.data = mem_pkg::mem_data_t'(data);
		exp_wr.push_back(w);
	endtask

	task automatic push_word16(input loader_pkg::word16_t w);
		file_bytes.push_back(w[15:8]);
		file_bytes.push_back(w[7:0]);
	endtask

	task automatic build_prg(input row_t row);
		mem_pkg::mem_data_t b;
		logic [15:0]        end_a;
		push_word16({row.load[7:0], row.load[15:8]});
		for (int i = 0; i < row.len0; i++) begin
			b = mem_pkg::mem_data_t'($random(seed));
			file_bytes.push_back(b);
			add_wr(row.load + i, b);
		end
		end_a = row.load + row.len0;
		// BASIC pointers in ascending page zero order
		add_wr('h2B, 'h01);
		add_wr('h2C, 'h08);
		for (int a = 'h2D; a <= 'h32; a++) begin
			add_wr(a, a[0] ? end_a[7:0] : end_a[15:8]);
		end
		add_wr('hAC, 'h00);
		add_wr('hAD, 'h00);
		add_wr('hAE, end_a[7:0]);
		add_wr('hAF, end_a[15:8]);
	endtask

	task automatic build_crt(input row_t row);
		mem_pkg::mem_addr_t base;
		mem_pkg::mem_data_t b;
		bank_rec_t          rec;
		int                 len;
		int                 align;
		align = 1 << `LDR_BANK_ALIGN_BITS;
		for (int i = 0; i < `LDR_CRT_PKT_START; i++) begin
			file_bytes.push_back(8'h00);
		end
		file_bytes[`LDR_CRT_ID_HI] = row.id[15:8];
		file_bytes[`LDR_CRT_ID_LO] = row.id[7:0];
		file_bytes[`LDR_CRT_EXROM] = row.exrom;
		file_bytes[`LDR_CRT_GAME]  = row.game;
		base = `LDR_CRT_BASE;
		for (int p = 0; p < 2; p++) begin
			len       = (p == 0) ? row.len0 : row.len1;
			rec.btype = (p == 0) ? 8'h00 : 8'h02;
			rec.num   = loader_pkg::word16_t'(p);
			rec.laddr = (p == 0) ? row.laddr0 : row.laddr1;
			rec.size  = loader_pkg::word16_t'(len);
			rec.raddr = base;
			exp_bank.push_back(rec);
			// Chip header, 32-bit length counts the header too
			push_word16(16'h4348);
			push_word16(16'h4950);
			push_word16(16'h0000);
			push_word16(loader_pkg::word16_t'(`LDR_CHIP_HDR_LEN + len));
			push_word16({8'h00, rec.btype});
			push_word16(rec.num);
			push_word16(rec.laddr);
			push_word16(rec.size);
			for (int i = 0; i < len; i++) begin
				b = mem_pkg::mem_data_t'($random(seed));
				file_bytes.push_back(b);
				add_wr(base + i, b);
			end
			// Next packet on the following 8 KB boundary
			base = mem_pkg::mem_addr_t'(((base + len + align - 1) / align) * align);
		end
	endtask

	function automatic int row_cycles(input row_t row);
		int bytes;
		int writes;
		if (row.idx == `LDR_IDX_PRG) begin
			bytes  = 2 + row.len0;
			writes = row.len0 + PTR_WRITES;
			return 4 * (bytes + 4 * writes + row.hold + 2 * `LDR_MEMINIT_END);
		end
		bytes  = `LDR_CRT_PKT_START + 2 * `LDR_CHIP_HDR_LEN + row.len0 + row.len1;
		writes = row.len0 + row.len1;
		return 4 * (bytes + 4 * writes + row.hold);
	endfunction

	// ==============================
	// One table row
	// ==============================
	task automatic run_row(input int r);
		row_t row;
		row       = stim_rows[r];
		file_bytes = {};
		exp_wr     = {};
		exp_bank   = {};
		got_wr     = {};
		got_bank   = {};
		wait_seen  = 1'b0;
		if (row.idx == `LDR_IDX_PRG) begin
			build_prg(row);
		end else begin
			build_crt(row);
		end
		hold_until = cycle_cnt + row.hold;
		send_file(row.idx);
		if (row.idx == `LDR_IDX_CRT) begin
			check_bit(cart_attached_o, 1'b0, "cart_attached_o before download end");
			while (!cart_attached_o) begin
				@(negedge clk_sys);
			end
			check_word16(cart_id_o, row.id, "cart_id_o");
			check_flag_byte(cart_exrom_o, row.exrom, "cart_exrom_o");
			check_flag_byte(cart_game_o, row.game, "cart_game_o");
		end
		while (got_wr.size() < exp_wr.size()) begin
			@(negedge clk_sys);
		end
		// Page walk runs to the end of page zero before the next file
		if (row.idx == `LDR_IDX_PRG) begin
			repeat (`LDR_MEMINIT_END) @(negedge clk_sys);
		end
		if (got_wr.size() != exp_wr.size()) begin
			report_error($sformatf("row %0d gave %0d memory writes, expected %0d",
				r, got_wr.size(), exp_wr.size()));
		end
		foreach (exp_wr[i]) begin
			check_mem_wr(got_wr[i].addr, got_wr[i].data, exp_wr[i].addr, exp_wr[i].data,
				$sformatf("row %0d write %0d", r, i));
		end
		if (got_bank.size() != exp_bank.size()) begin
			report_error($sformatf("row %0d gave %0d bank records, expected %0d",
				r, got_bank.size(), exp_bank.size()));
		end
		foreach (exp_bank[i]) begin
			check_bank_type(got_bank[i].btype, exp_bank[i].btype, "bank_type_o");
			check_word16(got_bank[i].num, exp_bank[i].num, "bank_num_o");
			check_word16(got_bank[i].laddr, exp_bank[i].laddr, "bank_laddr_o");
			check_word16(got_bank[i].size, exp_bank[i].size, "bank_size_o");
			check_bank_raddr(got_bank[i].raddr, exp_bank[i].raddr, "bank_raddr_o");
		end
		if (row.hold != 0) begin
			check_bit(wait_seen, 1'b1, "ioctl_wait_o while slots withheld");
		end
	endtask

	initial begin
		clk_sys          = 1'b0;
		reset_n          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = '0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		hold_until       = 0;
		// idx, load, len0, len1, id, exrom, game, laddr0, laddr1, hold
		stim_rows[0] = '{8'd4, 16'h0801, 8'd6, 8'd0, 16'h0000, 8'h00, 8'h00,
			16'h0000, 16'h0000, 8'd0};
		stim_rows[1] = '{8'd5, 16'h0000, 8'd5, 8'd3, 16'h0013, 8'h01, 8'h00,
			16'h8000, 16'hA000, 8'd0};
		stim_rows[2] = '{8'd4, 16'h0801, 8'd12, 8'd0, 16'h0000, 8'h00, 8'h00,
			16'h0000, 16'h0000, 8'd40};
		cycle_limit = 5;
		for (int r = 0; r < ROWS; r++) begin
			cycle_limit = cycle_limit + row_cycles(stim_rows[r]);
		end
		repeat (5) @(posedge clk_sys);
		#1;
		reset_n = 1'b1;
		@(negedge clk_sys);
		check_bit(mem_we_o, 1'b0, "mem_we_o after reset");
		check_bit(ioctl_wait_o, 1'b0, "ioctl_wait_o after reset");
		check_bit(bank_hdr_wr_o, 1'b0, "bank_hdr_wr_o after reset");
		check_bit(cart_attached_o, 1'b0, "cart_attached_o after reset");
		for (int r = 0; r < ROWS; r++) begin
			run_row(r);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hdl
+incdir+tests
hdl/loader_pkg.sv
hdl/mem_pkg.sv
hdl/image_parser.sv
hdl/write_queue.sv
hdl/slot_writer.sv
hdl/loader_top.sv
tests/tb_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the loader testbench with Verilator and run it
# The exit status is that of the simulation
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tb_loader -f verilog.f -Mdir obj_dir &&
./obj_dir/Vtb_loader || exit 1
